// File: csr_pkg.sv
`default_nettype none

package csr_pkg;

    localparam int XLEN_DEF = 32;

    // funct3 of the SYSTEM opcode, bit 2 picks uimm
    typedef enum logic [2:0] {
        CSRRW  = 3'b001,
        CSRRS  = 3'b010,
        CSRRC  = 3'b011,
        CSRRWI = 3'b101,
        CSRRSI = 3'b110,
        CSRRCI = 3'b111
    } csr_op_e;

    typedef enum logic [11:0] {
        CSR_MTVEC     = 12'h305,
        CSR_MSCRATCH  = 12'h340,
        CSR_MEPC      = 12'h341,
        CSR_MCAUSE    = 12'h342,
        CSR_MCYCLE    = 12'hB00,
        CSR_MINSTRET  = 12'hB02,
        CSR_CYCLE     = 12'hC00, // Alias of mcycle
        CSR_TIME      = 12'hC01, // Alias of mcycle
        CSR_INSTRET   = 12'hC02, // Alias of minstret
        CSR_MVENDORID = 12'hF11,
        CSR_MARCHID   = 12'hF12,
        CSR_MIMPID    = 12'hF13,
        CSR_MHARTID   = 12'hF14
    } csr_addr_e;

    typedef enum logic [3:0] {
        EXC_INSTR_MISALIGNED = 4'd0,
        EXC_ILLEGAL_INSTR    = 4'd2,
        EXC_BREAKPOINT       = 4'd3,
        EXC_LOAD_MISALIGNED  = 4'd4,
        EXC_ECALL_M          = 4'd11
    } exc_cause_e;

    typedef enum logic [1:0] {
        IDLE,
        EXEC,
        ACK
    } hs_state_e;

    localparam logic [31:0] MVENDORID = 32'h0000_0000; // Non-commercial
    localparam logic [31:0] MARCHID   = 32'h0000_0017;
    localparam logic [31:0] MIMPID    = 32'h0001_0200;

    // AND masks applied on write, wide enough for XLEN 64
    localparam logic [63:0] MTVEC_MASK = ~64'h2;
    localparam logic [63:0] MEPC_MASK  = ~64'h1;

endpackage

`default_nettype wire

// File: csr_if.sv
`timescale 1ns/10ps
`default_nettype none

interface csr_if #(
    parameter int XLEN = csr_pkg::XLEN_DEF
);
    import csr_pkg::*;

    logic            valid;   // One-cycle access strobe
    logic [11:0]     addr;
    csr_op_e         op;
    logic [XLEN-1:0] src;     // rs1 data or zero-extended uimm
    logic            rd_zero;
    logic [XLEN-1:0] rdata;
    logic            exception;

    modport master (
        output valid, addr, op, src, rd_zero,
        input  rdata, exception
    );

    modport slave (
        input  valid, addr, op, src, rd_zero,
        output rdata, exception
    );

endinterface

`default_nettype wire

// File: csr_regs.sv
`timescale 1ns/10ps
`default_nettype none

module csr_regs #(
    parameter int XLEN = csr_pkg::XLEN_DEF
) (
    input  logic                  clk,
    input  logic                  rst,
    csr_if.slave                  csr,
    input  logic                  inst_retired,
    input  logic                  trap_update,
    input  csr_pkg::exc_cause_e   trap_mcause,
    input  logic [XLEN-1:0]       trap_mepc,
    output logic [XLEN-1:0]       mtvec
);
    import csr_pkg::*;

    logic [XLEN-1:0] mtvec_q;
    logic [XLEN-1:0] mscratch_q;
    logic [XLEN-1:0] mepc_q;
    logic [XLEN-1:0] mcause_q;
    logic [XLEN-1:0] mcycle_q;
    logic [XLEN-1:0] minstret_q;

    logic [XLEN-1:0] old_val;
    logic [XLEN-1:0] wdata;
    logic            bad_addr;
    logic            read_only;
    logic            is_rw;
    logic            wr_req;
    logic            do_write;

    assign mtvec = mtvec_q;

    assign read_only = (csr.addr[11:10] == 2'b11);
    assign is_rw     = (csr.op == CSRRW) || (csr.op == CSRRWI);
    // Set and clear with a zero source are pure reads
    assign wr_req    = is_rw || (csr.src != '0);

    assign csr.exception = bad_addr || (wr_req && read_only);
    assign csr.rdata     = (is_rw && csr.rd_zero) ? '0 : old_val;

    assign do_write = csr.valid && wr_req && !csr.exception;

    // Address decode
    always_comb begin
        bad_addr = 1'b0;
        case (csr.addr)
            CSR_MTVEC:     old_val = mtvec_q;
            CSR_MSCRATCH:  old_val = mscratch_q;
            CSR_MEPC:      old_val = mepc_q;
            CSR_MCAUSE:    old_val = mcause_q;
            CSR_MCYCLE:    old_val = mcycle_q;
            CSR_MINSTRET:  old_val = minstret_q;
            CSR_CYCLE:     old_val = mcycle_q;
            CSR_TIME:      old_val = mcycle_q;
            CSR_INSTRET:   old_val = minstret_q;
            CSR_MVENDORID: old_val = XLEN'(MVENDORID);
            CSR_MARCHID:   old_val = XLEN'(MARCHID);
            CSR_MIMPID:    old_val = XLEN'(MIMPID);
            CSR_MHARTID:   old_val = '0; // Single hart
            default: begin
                bad_addr = 1'b1;
                old_val  = '0;
            end
        endcase
    end

    // Read-modify-write data
    always_comb begin
        case (csr.op)
            CSRRW, CSRRWI: wdata = csr.src;
            CSRRS, CSRRSI: wdata = old_val | csr.src;
            CSRRC, CSRRCI: wdata = old_val & ~csr.src;
            default:       wdata = old_val; // Undefined funct3 leaves value
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mtvec_q    <= '0;
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
            mcycle_q   <= '0;
            minstret_q <= '0;
        end else begin
            mcycle_q <= mcycle_q + XLEN'(1);
            if (inst_retired) begin
                minstret_q <= minstret_q + XLEN'(1);
            end

            // Later assignments override the increments above
            if (do_write) begin
                case (csr.addr)
                    CSR_MTVEC:    mtvec_q    <= wdata & MTVEC_MASK[XLEN-1:0];
                    CSR_MSCRATCH: mscratch_q <= wdata;
                    CSR_MEPC:     mepc_q     <= wdata & MEPC_MASK[XLEN-1:0];
                    CSR_MCAUSE:   mcause_q   <= wdata;
                    CSR_MCYCLE:   mcycle_q   <= wdata;
                    CSR_MINSTRET: minstret_q <= wdata;
                    default: ;
                endcase
            end

            // Trap entry takes priority over a CSR write
            if (trap_update) begin
                mcause_q <= XLEN'(trap_mcause);
                mepc_q   <= trap_mepc & MEPC_MASK[XLEN-1:0];
            end
        end
    end

endmodule

`default_nettype wire

// File: csr_access.sv
`timescale 1ns/10ps
`default_nettype none

module csr_access #(
    parameter int XLEN = csr_pkg::XLEN_DEF
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               csr_req,
    output logic               csr_ack,
    input  logic [11:0]        csr_addr,
    input  csr_pkg::csr_op_e   csr_op,
    input  logic [4:0]         csr_rd,
    input  logic [4:0]         csr_uimm,
    input  logic [XLEN-1:0]    csr_rs1_data,
    output logic [XLEN-1:0]    csr_rdata,
    output logic               csr_exc,
    csr_if.master              csr
);
    import csr_pkg::*;

    hs_state_e       state_q;
    logic [11:0]     addr_q;
    csr_op_e         op_q;
    logic [XLEN-1:0] src_q;
    logic            rd_zero_q;

    assign csr.valid   = (state_q == EXEC);
    assign csr.addr    = addr_q;
    assign csr.op      = op_q;
    assign csr.src     = src_q;
    assign csr.rd_zero = rd_zero_q;

    assign csr_ack = (state_q == ACK);

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: if (csr_req) state_q <= EXEC;
                EXEC: state_q <= ACK;
                ACK:  if (!csr_req) state_q <= IDLE; // Wait for req release
                default: state_q <= IDLE;
            endcase
        end
    end

    // Request latch
    always_ff @(posedge clk) begin
        if (state_q == IDLE && csr_req) begin
            addr_q    <= csr_addr;
            op_q      <= csr_op;
            rd_zero_q <= (csr_rd == 5'd0);
            if (csr_op[2]) begin
                src_q <= {{(XLEN-5){1'b0}}, csr_uimm};
            end else begin
                src_q <= csr_rs1_data;
            end
        end
    end

    // Result held until the handshake completes
    always_ff @(posedge clk) begin
        if (state_q == EXEC) begin
            csr_rdata <= csr.rdata;
            csr_exc   <= csr.exception;
        end
    end

endmodule

`default_nettype wire

// File: trap_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module trap_ctrl #(
    parameter int XLEN = csr_pkg::XLEN_DEF
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  trap_req,
    output logic                  trap_ack,
    input  csr_pkg::exc_cause_e   trap_cause,
    input  logic [XLEN-1:0]       trap_pc,
    output logic [XLEN-1:0]       trap_target,
    input  logic [XLEN-1:0]       mtvec,
    output logic                  trap_update,
    output csr_pkg::exc_cause_e   trap_mcause,
    output logic [XLEN-1:0]       trap_mepc
);
    import csr_pkg::*;

    hs_state_e       state_q;
    exc_cause_e      cause_q;
    logic [XLEN-1:0] pc_q;

    assign trap_update = (state_q == EXEC); // Single pulse per trap
    assign trap_mcause = cause_q;
    assign trap_mepc   = pc_q;
    assign trap_ack    = (state_q == ACK);

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: if (trap_req) state_q <= EXEC;
                EXEC: state_q <= ACK;
                ACK:  if (!trap_req) state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE && trap_req) begin
            cause_q <= trap_cause;
            pc_q    <= trap_pc;
        end
    end

    // Direct mode only, mode bits dropped from the base
    always_ff @(posedge clk) begin
        if (state_q == EXEC) begin
            trap_target <= {mtvec[XLEN-1:2], 2'b00};
        end
    end

endmodule

`default_nettype wire

// File: csr_top.sv
`timescale 1ns/10ps
`default_nettype none

module csr_top #(
    parameter int XLEN = csr_pkg::XLEN_DEF
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  inst_retired,

    input  logic                  csr_req,
    output logic                  csr_ack,
    input  logic [11:0]           csr_addr,
    input  csr_pkg::csr_op_e      csr_op,
    input  logic [4:0]            csr_rd,
    input  logic [4:0]            csr_uimm,
    input  logic [XLEN-1:0]       csr_rs1_data,
    output logic [XLEN-1:0]       csr_rdata,
    output logic                  csr_exc,

    input  logic                  trap_req,
    output logic                  trap_ack,
    input  csr_pkg::exc_cause_e   trap_cause,
    input  logic [XLEN-1:0]       trap_pc,
    output logic [XLEN-1:0]       trap_target
);
    import csr_pkg::*;

    logic            trap_update;
    exc_cause_e      trap_mcause;
    logic [XLEN-1:0] trap_mepc;
    logic [XLEN-1:0] mtvec;

    csr_if #(.XLEN(XLEN)) csr_bus ();

    csr_access #(.XLEN(XLEN)) u_csr_access (
        .clk          (clk),
        .rst          (rst),
        .csr_req      (csr_req),
        .csr_ack      (csr_ack),
        .csr_addr     (csr_addr),
        .csr_op       (csr_op),
        .csr_rd       (csr_rd),
        .csr_uimm     (csr_uimm),
        .csr_rs1_data (csr_rs1_data),
        .csr_rdata    (csr_rdata),
        .csr_exc      (csr_exc),
        .csr          (csr_bus.master)
    );

    csr_regs #(.XLEN(XLEN)) u_csr_regs (
        .clk          (clk),
        .rst          (rst),
        .csr          (csr_bus.slave),
        .inst_retired (inst_retired),
        .trap_update  (trap_update),
        .trap_mcause  (trap_mcause),
        .trap_mepc    (trap_mepc),
        .mtvec        (mtvec)
    );

    trap_ctrl #(.XLEN(XLEN)) u_trap_ctrl (
        .clk          (clk),
        .rst          (rst),
        .trap_req     (trap_req),
        .trap_ack     (trap_ack),
        .trap_cause   (trap_cause),
        .trap_pc      (trap_pc),
        .trap_target  (trap_target),
        .mtvec        (mtvec),
        .trap_update  (trap_update),
        .trap_mcause  (trap_mcause),
        .trap_mepc    (trap_mepc)
    );

endmodule

`default_nettype wire

// File: csr_checker.sv
`timescale 1ns/10ps
`default_nettype none

module csr_checker #(
    parameter int XLEN = 32
) (
    input logic            clk,
    input logic            rst,
    input logic            csr_req,
    input logic            csr_ack,
    input logic            trap_req,
    input logic            trap_ack,
    input logic            acc_valid,
    input logic            acc_exc,
    input logic [XLEN-1:0] mtvec_val,
    input logic [XLEN-1:0] mscratch_val
);

    // Ack is seen one edge after the edge that raised it
    csr_ack_rise: assert property (@(posedge clk) disable iff (rst)
        $rose(csr_ack) |-> $past(csr_req)) else $error("csr_ack rose without csr_req");

    trap_ack_rise: assert property (@(posedge clk) disable iff (rst)
        $rose(trap_ack) |-> $past(trap_req)) else $error("trap_ack rose without trap_req");

    csr_ack_fall: assert property (@(posedge clk) disable iff (rst)
        $fell(csr_ack) |-> $past(!csr_req)) else $error("csr_ack fell while req was high");

    trap_ack_fall: assert property (@(posedge clk) disable iff (rst)
        $fell(trap_ack) |-> $past(!trap_req)) else $error("trap_ack fell while req was high");

    // First cycle out of reset
    acks_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !csr_ack && !trap_ack) else $error("ack high right after reset");

    exc_no_write: assert property (@(posedge clk) disable iff (rst)
        acc_valid && acc_exc |=> $stable(mtvec_val) && $stable(mscratch_val))
        else $error("register changed on an access that raised an exception");

endmodule

bind csr_top csr_checker #(.XLEN(XLEN)) u_checker (
    .clk          (clk),
    .rst          (rst),
    .csr_req      (csr_req),
    .csr_ack      (csr_ack),
    .trap_req     (trap_req),
    .trap_ack     (trap_ack),
    .acc_valid    (csr_bus.valid),
    .acc_exc      (csr_bus.exception),
    .mtvec_val    (mtvec),
    .mscratch_val (u_csr_regs.mscratch_q)
);

`default_nettype wire

// File: tb_csr_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_csr_top;
    import csr_pkg::*;

    localparam int XLEN = 32;
    localparam int TIMEOUT = 1000; // About 150 handshakes of 4 to 6 cycles

    logic clk = 1'b0, rst, inst_retired, csr_req, csr_ack, csr_exc, trap_req, trap_ack;
    logic [11:0] csr_addr;
    csr_op_e csr_op;
    logic [4:0] csr_rd, csr_uimm;
    logic [XLEN-1:0] csr_rs1_data, csr_rdata, trap_pc, trap_target;
    exc_cause_e trap_cause;

    logic [15:0] lfsr = 16'd75;
    int cycle_cnt = 0, ack_cycle, value_errors = 0, exc_errors = 0;
    logic [31:0] last_rdata, v1, v2, m_mtvec = '0, m_mscratch = '0, m_mepc = '0, m_mcause = '0;
    logic last_exc;

    csr_top #(.XLEN(XLEN)) u_dut (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, got);
        assert (exp === got) else begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, got);
            value_errors++;
        end
    endtask

    task automatic run_access(input logic [11:0] addr, input csr_op_e op,
                              input logic [4:0] rd, uimm, input logic [31:0] rs1);
        csr_req = 1'b1;
        csr_addr = addr;
        csr_op = op;
        csr_rd = rd;
        csr_uimm = uimm;
        csr_rs1_data = rs1;
        do begin
            @(posedge clk);
            #2;
        end while (!csr_ack);
        last_rdata = csr_rdata;
        last_exc = csr_exc;
        ack_cycle = cycle_cnt;
        csr_req = 1'b0;
        do begin
            @(posedge clk);
            #2;
        end while (csr_ack);
    endtask

    // Checked access against the register model
    task automatic access_check(input string name, input logic [11:0] addr, input csr_op_e op,
                                input logic [4:0] rd, uimm, input logic [31:0] rs1);
        logic [31:0] src, old, nv;
        logic known, is_rw, wr, exp_exc;
        src = op[2] ? {27'd0, uimm} : rs1;
        is_rw = (op == CSRRW) || (op == CSRRWI);
        wr = is_rw || (src != 0);
        known = 1'b1;
        case (addr)
            12'h305: old = m_mtvec;
            12'h340: old = m_mscratch;
            12'h341: old = m_mepc;
            12'h342: old = m_mcause;
            12'hF11: old = MVENDORID;
            12'hF12: old = MARCHID;
            12'hF13: old = MIMPID;
            12'hF14: old = '0;
            12'hB00, 12'hB02, 12'hC00, 12'hC01, 12'hC02: old = 'x; // Counters
            default: known = 1'b0;
        endcase
        exp_exc = !known || (wr && addr[11:10] == 2'b11);
        run_access(addr, op, rd, uimm, rs1);
        assert (last_exc === exp_exc) else begin
            $display("[ERROR] %s exc: expected %b, actual %b", name, exp_exc, last_exc);
            exc_errors++;
        end
        if (!exp_exc) begin
            check_value(name, (is_rw && rd == 0) ? 32'd0 : old, last_rdata);
            if (wr) begin
                nv = is_rw ? src : (op[1:0] == 2'b10) ? (old | src) : (old & ~src);
                case (addr)
                    12'h305: m_mtvec = nv & ~32'h2;
                    12'h340: m_mscratch = nv;
                    12'h341: m_mepc = nv & ~32'h1;
                    12'h342: m_mcause = nv;
                    default: ;
                endcase
            end
        end
    endtask

    task automatic run_trap(input exc_cause_e cause, input logic [31:0] pc);
        trap_req = 1'b1;
        trap_cause = cause;
        trap_pc = pc;
        do begin
            @(posedge clk);
            #2;
        end while (!trap_ack);
        check_value("trap target", {m_mtvec[31:2], 2'b00}, trap_target);
        m_mcause = {28'd0, cause};
        m_mepc = pc & ~32'h1;
        trap_req = 1'b0;
        do begin
            @(posedge clk);
            #2;
        end while (trap_ack);
    endtask

    function automatic csr_op_e pick_op(input logic [31:0] i);
        case (i % 6)
            0: return CSRRW;
            1: return CSRRS;
            2: return CSRRC;
            3: return CSRRWI;
            4: return CSRRSI;
            default: return CSRRCI;
        endcase
    endfunction

    function automatic exc_cause_e pick_cause(input logic [31:0] i);
        case (i % 5)
            0: return EXC_INSTR_MISALIGNED;
            1: return EXC_ILLEGAL_INSTR;
            2: return EXC_BREAKPOINT;
            3: return EXC_LOAD_MISALIGNED;
            default: return EXC_ECALL_M;
        endcase
    endfunction

    function automatic logic [11:0] pick_addr(input logic [2:0] i);
        case (i)
            0: return 12'h305;
            1, 2: return 12'h340;
            3: return 12'h341;
            4: return 12'h342;
            5: return 12'h7C0; // Not implemented
            6: return 12'hF11;
            default: return 12'hF13;
        endcase
    endfunction

    initial begin
        logic [31:0] r, a, o, d, u, z, n, base;
        rst = 1'b1;
        inst_retired = 1'b0;
        csr_req = 1'b0;
        trap_req = 1'b0;
        csr_addr = '0;
        csr_op = CSRRW;
        csr_rd = '0;
        csr_uimm = '0;
        csr_rs1_data = '0;
        trap_cause = EXC_ECALL_M;
        trap_pc = '0;
        repeat (2) @(posedge clk);
        #2 rst = 1'b0;

        access_check("rmw csrrw", 12'h340, CSRRW, 5'd1, 5'd0, 32'hA5A5_1234);
        access_check("rmw csrrs", 12'h340, CSRRS, 5'd1, 5'd0, 32'h0000_0F00);
        access_check("rmw csrrc", 12'h340, CSRRC, 5'd2, 5'd0, 32'h0000_0004);
        access_check("rmw csrrwi", 12'h340, CSRRWI, 5'd0, 5'd9, 32'd0);
        access_check("rmw csrrsi", 12'h340, CSRRSI, 5'd3, 5'h12, 32'd0);
        access_check("rmw csrrci", 12'h340, CSRRCI, 5'd3, 5'h01, 32'd0);
        access_check("rmw zero set", 12'h340, CSRRS, 5'd4, 5'd0, 32'd0);
        access_check("rmw zero clear", 12'h340, CSRRCI, 5'd4, 5'd0, 32'd0);
        access_check("mtvec mask", 12'h305, CSRRW, 5'd1, 5'd0, 32'hFFFF_FFFF);
        access_check("mtvec readback", 12'h305, CSRRSI, 5'd1, 5'd0, 32'd0);
        access_check("mepc mask", 12'h341, CSRRW, 5'd1, 5'd0, 32'hFFFF_FFFF);
        access_check("mepc readback", 12'h341, CSRRSI, 5'd1, 5'd0, 32'd0);
        access_check("unknown addr", 12'h7C0, CSRRSI, 5'd1, 5'd0, 32'd0);
        access_check("write mvendorid", 12'hF11, CSRRW, 5'd1, 5'd0, 32'd5);
        access_check("set cycle", 12'hC00, CSRRSI, 5'd1, 5'd3, 32'd0);
        access_check("set instret", 12'hC02, CSRRS, 5'd1, 5'd0, 32'd1);
        access_check("mvendorid", 12'hF11, CSRRS, 5'd1, 5'd0, 32'd0);
        access_check("marchid", 12'hF12, CSRRSI, 5'd1, 5'd0, 32'd0);
        access_check("mimpid", 12'hF13, CSRRC, 5'd1, 5'd0, 32'd0);
        access_check("mhartid", 12'hF14, CSRRCI, 5'd1, 5'd0, 32'd0);

        // Fixed access latency makes edge counts comparable
        run_access(12'hB00, CSRRSI, 5'd1, 5'd0, 32'd0);
        v1 = last_rdata;
        a = ack_cycle;
        rand_bits(3, r);
        repeat (r) begin
            @(posedge clk);
            #2;
        end
        run_access(12'hB00, CSRRSI, 5'd1, 5'd0, 32'd0);
        check_value("mcycle delta", v1 + (ack_cycle - a), last_rdata);
        run_access(12'hC00, CSRRS, 5'd1, 5'd0, 32'd0);
        check_value("cycle alias", v1 + (ack_cycle - a), last_rdata);
        run_access(12'hC01, CSRRSI, 5'd1, 5'd0, 32'd0);
        check_value("time alias", v1 + (ack_cycle - a), last_rdata);
        run_access(12'hB02, CSRRSI, 5'd1, 5'd0, 32'd0);
        v2 = last_rdata;
        n = 0;
        for (int i = 0; i < 8; i++) begin
            rand_bits(1, r);
            inst_retired = r[0];
            n += {31'd0, r[0]};
            @(posedge clk);
            #2;
        end
        inst_retired = 1'b0;
        run_access(12'hC02, CSRRSI, 5'd1, 5'd0, 32'd0);
        check_value("instret count", v2 + n, last_rdata);

        for (int t = 0; t < 10; t++) begin
            rand_bits(32, base);
            access_check("trap mtvec", 12'h305, CSRRW, 5'd1, 5'd0, base);
            rand_bits(3, r);
            rand_bits(32, d);
            run_trap(pick_cause(r), d);
            access_check("trap mcause", 12'h342, CSRRSI, 5'd1, 5'd0, 32'd0);
            access_check("trap mepc", 12'h341, CSRRS, 5'd1, 5'd0, 32'd0);
        end

        // Held req must give a single access
        csr_req = 1'b1;
        csr_addr = 12'h340;
        csr_op = CSRRS;
        csr_rd = 5'd1;
        csr_rs1_data = 32'h8000_0001;
        do begin
            @(posedge clk);
            #2;
        end while (!csr_ack);
        check_value("backpressure rdata", m_mscratch, csr_rdata);
        repeat (4) begin
            @(posedge clk);
            #2;
            check_value("backpressure ack", 32'd1, {31'd0, csr_ack});
            check_value("backpressure hold", m_mscratch, csr_rdata);
        end
        m_mscratch = m_mscratch | 32'h8000_0001;
        csr_req = 1'b0;
        do begin
            @(posedge clk);
            #2;
        end while (csr_ack);
        access_check("backpressure read", 12'h340, CSRRSI, 5'd1, 5'd0, 32'd0);

        for (int k = 0; k < 50; k++) begin
            rand_bits(3, r);
            rand_bits(3, o);
            rand_bits(5, u);
            rand_bits(1, z);
            rand_bits(32, d);
            access_check("random", pick_addr(r[2:0]), pick_op(o), u[4:0],
                         u[4:0] ^ 5'h0A, z[0] ? 32'd0 : d);
        end

        $display("Value errors: %0d, exception flag errors: %0d", value_errors, exc_errors);
        if (value_errors == 0 && exc_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: csr_sys.f
csr_pkg.sv
csr_if.sv
csr_regs.sv
csr_access.sv
trap_ctrl.sv
csr_top.sv
csr_checker.sv
tb_csr_top.sv

// File: run.sh
#!/bin/sh
# Build and run the CSR block testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f csr_sys.f --top-module tb_csr_top -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/Vtb_csr_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" sim.log; then
    exit 1
fi
exit 0
